//--- Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_stream_fork_join -f stream_fork_join.f -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- sim/tb_stream_fork_join.sv
// testbench for the fork/join datapath: clock, reset, reference model, checks and directed tests

`timescale 1ns/1ps
`default_nettype none

module tb_stream_fork_join;

    import stream_pkg::*;

    localparam int RESET_CYCLES     = 16;
    localparam int STREAM_WORDS     = 64;
    localparam int EXPECTED_LATENCY = 5;
    localparam int FILL_LIMIT       = 16;
    localparam int FULL_STALL       = 8;
    localparam int WAIT_LIMIT       = 40;
    localparam int STREAM_LIMIT     = 2000;
    localparam int IDLE_CYCLES      = 10;
    localparam int READY_LOW        = 0;
    localparam int READY_HIGH       = 1;
    localparam int READY_RANDOM     = 2;

    logic    clk;
    logic    rst;
    data_t   s_data;
    logic    s_valid;
    logic    s_ready;
    result_t m_data;
    logic    m_valid;
    logic    m_ready;
    logic    busy;

    integer  seed;
    int      error_count;
    int      check_count;
    int      issued_count;
    int      accepted_count;
    int      received_count;
    logic    in_fire;
    logic    held_valid;
    logic    held_ready;
    result_t held_data;
    result_t expected_q[$];

    stream_fork_join u_dut (
        .clk     (clk),
        .rst     (rst),
        .s_data  (s_data),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_data  (m_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .busy    (busy)
    );

    always #10 clk = ~clk;

    // bit count in bits 15..10 above the byte sum in bits 9..0
    function automatic result_t expected_result(input data_t word);
        sum_t   sum;
        count_t ones;
        sum  = '0;
        ones = '0;
        for (int b = 0; b < 4; b++) begin
            sum = sum + sum_t'(word[8*b +: 8]);
        end
        for (int i = 0; i < 32; i++) begin
            ones = ones + count_t'(word[i]);
        end
        return {ones, sum};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("At %0t ns: %s", $time, what);
    endtask

    task automatic clear_counters();
        issued_count   = 0;
        accepted_count = 0;
        received_count = 0;
        in_fire        = 1'b0;
        held_valid     = 1'b0;
        expected_q.delete();
    endtask

    // one clock cycle: drive on the falling edge, then look at the registered outputs,
    // which tell what the next rising edge will transfer
    task automatic cycle_step(input int word_limit, input int ready_mode);
        logic [31:0] rnd;
        @(negedge clk);
        if (in_fire) begin
            s_valid = 1'b0;
        end
        if (!s_valid && issued_count < word_limit) begin
            s_data  = $random(seed);
            s_valid = 1'b1;
            issued_count++;
        end
        rnd = $random(seed);
        case (ready_mode)
            READY_LOW:  m_ready = 1'b0;
            READY_HIGH: m_ready = 1'b1;
            default:    m_ready = rnd[0];
        endcase
        // a stalled output word must still be there, unchanged
        if (held_valid && !held_ready) begin
            check_value("m_valid", 32'(m_valid), 32'h1);
            check_value("m_data", 32'(m_data), 32'(held_data));
        end
        in_fire = s_valid && s_ready;
        if (in_fire) begin
            expected_q.push_back(expected_result(s_data));
            accepted_count++;
        end
        if (m_valid && m_ready) begin
            if (expected_q.size() == 0) begin
                report_problem("an output word came out with no input word left to match");
            end else begin
                check_value("m_data", 32'(m_data), 32'(expected_q.pop_front()));
            end
            received_count++;
        end
        held_valid = m_valid;
        held_ready = m_ready;
        held_data  = m_data;
    endtask

    task automatic test_reset();
        int cycles;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("m_valid", 32'(m_valid), 32'h0);
            check_value("busy", 32'(busy), 32'h0);
            check_value("s_ready", 32'(s_ready), 32'h0);
        end
        rst = 1'b0;
        @(negedge clk);
        check_value("m_valid", 32'(m_valid), 32'h0);
        check_value("busy", 32'(busy), 32'h0);
        cycles = 0;
        while (!s_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!s_ready) begin
            report_problem("timeout: the input never became ready after reset");
        end
    endtask

    task automatic test_single_word();
        result_t expected;
        int      cycles;
        int      edges;
        // count 17 above byte sum 511
        expected = expected_result(32'hFFFF0001);
        @(negedge clk);
        s_data  = 32'hFFFF0001;
        s_valid = 1'b1;
        m_ready = 1'b1;
        cycles  = 0;
        while (!s_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!s_ready) begin
            report_problem("timeout: the single word was never accepted");
        end else begin
            @(negedge clk);
            s_valid = 1'b0;
            edges   = 0;
            while (!m_valid && edges < WAIT_LIMIT) begin
                @(negedge clk);
                edges++;
            end
            if (!m_valid) begin
                report_problem("timeout: no result came out for the single word");
            end else begin
                // the output transfer happens on the edge after this one
                if (edges + 1 != EXPECTED_LATENCY) begin
                    report_problem($sformatf("the result took %0d cycles instead of %0d",
                                             edges + 1, EXPECTED_LATENCY));
                end
                check_value("m_data", 32'(m_data), 32'(expected));
                @(negedge clk);
                check_value("m_valid", 32'(m_valid), 32'h0);
                check_value("busy", 32'(busy), 32'h0);
            end
        end
    endtask

    task automatic run_stream(input int ready_mode);
        int cycles;
        clear_counters();
        cycles = 0;
        while (received_count < STREAM_WORDS && cycles < STREAM_LIMIT) begin
            cycle_step(STREAM_WORDS, ready_mode);
            cycles++;
        end
        if (received_count < STREAM_WORDS) begin
            report_problem("timeout: not every streamed word came out");
        end
        // with the output open, any extra word would show up here
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            cycle_step(STREAM_WORDS, READY_HIGH);
        end
        check_value("received words", 32'(received_count), 32'(STREAM_WORDS));
        check_value("busy", 32'(busy), 32'h0);
    endtask

    task automatic test_back_to_back();
        run_stream(READY_HIGH);
    endtask

    task automatic test_random_ready();
        run_stream(READY_RANDOM);
    endtask

    task automatic test_backpressure();
        int cycles;
        int stall_cycles;
        clear_counters();
        cycles       = 0;
        stall_cycles = 0;
        while (stall_cycles < FULL_STALL && cycles < WAIT_LIMIT) begin
            cycle_step(STREAM_LIMIT, READY_LOW);
            if (s_valid && !s_ready) begin
                stall_cycles++;
            end else begin
                stall_cycles = 0;
            end
            cycles++;
        end
        if (stall_cycles < FULL_STALL) begin
            report_problem("timeout: the input kept accepting words with the output stalled");
        end
        if (accepted_count == 0 || accepted_count > FILL_LIMIT) begin
            report_problem($sformatf("the input stalled after %0d words, outside 1 to %0d",
                                     accepted_count, FILL_LIMIT));
        end
        check_value("m_valid", 32'(m_valid), 32'h1);
        // release the output; the word still offered at the input goes in as well
        cycles = 0;
        while ((s_valid || expected_q.size() != 0) && cycles < WAIT_LIMIT) begin
            cycle_step(issued_count, READY_HIGH);
            cycles++;
        end
        if (s_valid || expected_q.size() != 0) begin
            report_problem("timeout: the stored words did not drain");
        end
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            cycle_step(issued_count, READY_HIGH);
            cycles++;
        end
        if (busy) begin
            report_problem("timeout: busy stayed high after the drain");
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        s_data      = '0;
        s_valid     = 1'b0;
        m_ready     = 1'b0;
        seed        = 32'h0add933e;
        error_count = 0;
        check_count = 0;
        clear_counters();
        test_reset();
        test_single_word();
        test_back_to_back();
        test_random_ready();
        test_backpressure();
        $display("Finished with %0d checks and %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/bit_count_lane.sv
// two-stage lane that counts the set bits of each word

`timescale 1ns/1ps
`default_nettype none

module bit_count_lane (
    input  wire                    clk,
    input  wire                    rst,

    input  wire stream_pkg::data_t s_data,
    input  wire                    s_valid,
    output logic                   s_ready,

    output stream_pkg::count_t     m_data,
    output logic                   m_valid,
    input  wire                    m_ready,

    output logic                   busy
);

    import stream_pkg::*;

    count_t low_count;
    count_t high_count;
    logic   st1_valid;
    logic   st1_ready;
    logic   st2_ready;

    function automatic count_t half_count(input logic [DATA_WIDTH/2-1:0] bits);
        count_t total;
        total = '0;
        for (int i = 0; i < DATA_WIDTH / 2; i++) begin
            total = total + count_t'(bits[i]);
        end
        return total;
    endfunction

    // each stage moves on when the next one is empty or draining
    assign st2_ready = !m_valid || m_ready;
    assign st1_ready = !st1_valid || st2_ready;
    assign s_ready   = st1_ready;
    assign busy      = st1_valid || m_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            st1_valid <= 1'b0;
            m_valid   <= 1'b0;
        end else begin
            if (st1_ready) begin
                st1_valid <= s_valid;
            end
            if (st2_ready) begin
                m_valid <= st1_valid;
            end
        end
    end

    // stage one counts the halves, stage two adds them
    always_ff @(posedge clk) begin
        if (s_valid && st1_ready) begin
            low_count  <= half_count(s_data[DATA_WIDTH/2-1:0]);
            high_count <= half_count(s_data[DATA_WIDTH-1:DATA_WIDTH/2]);
        end
        if (st1_valid && st2_ready) begin
            m_data <= low_count + high_count;
        end
    end

endmodule

`default_nettype wire

//--- source/byte_sum_lane.sv
// single-stage lane that adds the four bytes of each word

`timescale 1ns/1ps
`default_nettype none

module byte_sum_lane (
    input  wire                    clk,
    input  wire                    rst,

    input  wire stream_pkg::data_t s_data,
    input  wire                    s_valid,
    output logic                   s_ready,

    output stream_pkg::sum_t       m_data,
    output logic                   m_valid,
    input  wire                    m_ready,

    output logic                   busy
);

    import stream_pkg::*;

    sum_t byte_sum;

    // every byte is widened before the add so no carry is lost
    assign byte_sum = sum_t'(s_data[7:0]) + sum_t'(s_data[15:8])
                    + sum_t'(s_data[23:16]) + sum_t'(s_data[31:24]);

    // room when the result register is empty or drains this cycle
    assign s_ready = !m_valid || m_ready;
    assign busy    = m_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (s_valid && s_ready) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            m_data <= byte_sum;
        end
    end

endmodule

`default_nettype wire

//--- source/data_joiner.sv
// joiner that pairs a byte sum with a bit count and buffers the packed word

`timescale 1ns/1ps
`default_nettype none

module data_joiner (
    input  wire                      clk,
    input  wire                      rst,

    input  wire stream_pkg::sum_t    sum_data,
    input  wire                      sum_valid,
    output logic                     sum_ready,

    input  wire stream_pkg::count_t  count_data,
    input  wire                      count_valid,
    output logic                     count_ready,

    output wire stream_pkg::result_t m_data,
    output wire                      m_valid,
    input  wire                      m_ready,

    output wire                      busy
);

    import stream_pkg::*;

    result_t packed_data;
    logic    pair_valid;
    logic    out_ready;

    // the faster sum lane holds its word until the count for it arrives
    assign pair_valid  = sum_valid && count_valid;
    assign sum_ready   = pair_valid && out_ready;
    assign count_ready = pair_valid && out_ready;

    assign packed_data = {count_data, sum_data};

    pipeline_insert_ff #(.WIDTH(RESULT_WIDTH)) u_ff_out (
        .clk      (clk),
        .rst      (rst),
        .s_data   (packed_data),
        .s_valid  (pair_valid),
        .s_ready  (out_ready),
        .m_data   (m_data),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .buffered (busy)
    );

    // a pair taken from the lanes is presented at the output on the next cycle
    assert property (@(posedge clk) disable iff (rst)
        sum_ready |=> m_valid);

endmodule

`default_nettype wire

//--- source/data_splitter.sv
// broadcast splitter with an input buffer and one output buffer per branch

`timescale 1ns/1ps
`default_nettype none

module data_splitter (
    input  wire                    clk,
    input  wire                    rst,

    input  wire stream_pkg::data_t s_data,
    input  wire                    s_valid,
    output wire                    s_ready,

    output wire stream_pkg::data_t sum_data,
    output wire                    sum_valid,
    input  wire                    sum_ready,

    output wire stream_pkg::data_t count_data,
    output wire                    count_valid,
    input  wire                    count_ready,

    output wire                    busy
);

    import stream_pkg::*;

    data_t in_data;
    logic  in_valid;
    logic  in_ready;
    logic  push_valid;
    logic  sum_in_ready;
    logic  count_in_ready;
    logic  in_busy;
    logic  sum_busy;
    logic  count_busy;

    pipeline_insert_ff #(.WIDTH(DATA_WIDTH)) u_ff_in (
        .clk      (clk),
        .rst      (rst),
        .s_data   (s_data),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .m_data   (in_data),
        .m_valid  (in_valid),
        .m_ready  (in_ready),
        .buffered (in_busy)
    );

    // the word leaves the input buffer only when both branches can take it,
    // so each branch sees every word exactly once
    assign in_ready   = sum_in_ready && count_in_ready;
    assign push_valid = in_valid && in_ready;

    pipeline_insert_ff #(.WIDTH(DATA_WIDTH)) u_ff_sum (
        .clk      (clk),
        .rst      (rst),
        .s_data   (in_data),
        .s_valid  (push_valid),
        .s_ready  (sum_in_ready),
        .m_data   (sum_data),
        .m_valid  (sum_valid),
        .m_ready  (sum_ready),
        .buffered (sum_busy)
    );

    pipeline_insert_ff #(.WIDTH(DATA_WIDTH)) u_ff_count (
        .clk      (clk),
        .rst      (rst),
        .s_data   (in_data),
        .s_valid  (push_valid),
        .s_ready  (count_in_ready),
        .m_data   (count_data),
        .m_valid  (count_valid),
        .m_ready  (count_ready),
        .buffered (count_busy)
    );

    assign busy = in_busy || sum_busy || count_busy;

    // a broadcast word shows up at both branch outputs one cycle later
    assert property (@(posedge clk) disable iff (rst)
        push_valid |=> sum_valid && count_valid);

endmodule

`default_nettype wire

//--- source/pipeline_insert_ff.sv
// two-entry registered skid buffer for one valid/ready stream boundary

`timescale 1ns/1ps
`default_nettype none

module pipeline_insert_ff #(
    parameter int WIDTH = 32
) (
    input  wire              clk,
    input  wire              rst,

    input  wire  [WIDTH-1:0] s_data,
    input  wire              s_valid,
    output logic             s_ready,

    output logic [WIDTH-1:0] m_data,
    output logic             m_valid,
    input  wire              m_ready,

    output logic             buffered
);

    typedef enum logic [1:0] {
        EMPTY,
        ONE,
        TWO
    } ff_state_t;

    ff_state_t        state;
    ff_state_t        state_next;
    logic [WIDTH-1:0] skid_data;
    logic             s_take;

    assign s_take   = s_valid && s_ready;
    assign buffered = (state != EMPTY);

    always_comb begin
        state_next = state;
        case (state)
            EMPTY: begin
                if (s_take) begin
                    state_next = ONE;
                end
            end
            ONE: begin
                if (s_take && !m_ready) begin
                    state_next = TWO;
                end else if (!s_take && m_ready) begin
                    state_next = EMPTY;
                end
            end
            TWO: begin
                if (m_ready) begin
                    state_next = ONE;
                end
            end
            default: begin
                state_next = EMPTY;
            end
        endcase
    end

    // both handshake outputs are decoded from the next state and registered
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= EMPTY;
            s_ready <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            state   <= state_next;
            s_ready <= (state_next != TWO);
            m_valid <= (state_next != EMPTY);
        end
    end

    // main register feeds the output, the skid register catches the word
    // that arrives while the output is stalled
    always_ff @(posedge clk) begin
        if ((state == EMPTY && s_take) || (state == ONE && s_take && m_ready)) begin
            m_data <= s_data;
        end else if (state == TWO && m_ready) begin
            m_data <= skid_data;
        end
        if (state == ONE && s_take && !m_ready) begin
            skid_data <= s_data;
        end
    end

    // a stalled word stays presented and unchanged until it is taken
    assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

//--- source/stream_fork_join.sv
// top level of the fork/join datapath: splitter, two lanes and joiner

`timescale 1ns/1ps
`default_nettype none

module stream_fork_join (
    input  wire                      clk,
    input  wire                      rst,

    input  wire stream_pkg::data_t   s_data,
    input  wire                      s_valid,
    output wire                      s_ready,

    output wire stream_pkg::result_t m_data,
    output wire                      m_valid,
    input  wire                      m_ready,

    output wire                      busy
);

    import stream_pkg::*;

    data_t  split_sum_data;
    logic   split_sum_valid;
    logic   split_sum_ready;
    data_t  split_count_data;
    logic   split_count_valid;
    logic   split_count_ready;
    sum_t   lane_sum_data;
    logic   lane_sum_valid;
    logic   lane_sum_ready;
    count_t lane_count_data;
    logic   lane_count_valid;
    logic   lane_count_ready;
    logic   split_busy;
    logic   sum_busy;
    logic   count_busy;
    logic   join_busy;

    data_splitter u_splitter (
        .clk         (clk),
        .rst         (rst),
        .s_data      (s_data),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .sum_data    (split_sum_data),
        .sum_valid   (split_sum_valid),
        .sum_ready   (split_sum_ready),
        .count_data  (split_count_data),
        .count_valid (split_count_valid),
        .count_ready (split_count_ready),
        .busy        (split_busy)
    );

    byte_sum_lane u_sum_lane (
        .clk     (clk),
        .rst     (rst),
        .s_data  (split_sum_data),
        .s_valid (split_sum_valid),
        .s_ready (split_sum_ready),
        .m_data  (lane_sum_data),
        .m_valid (lane_sum_valid),
        .m_ready (lane_sum_ready),
        .busy    (sum_busy)
    );

    bit_count_lane u_count_lane (
        .clk     (clk),
        .rst     (rst),
        .s_data  (split_count_data),
        .s_valid (split_count_valid),
        .s_ready (split_count_ready),
        .m_data  (lane_count_data),
        .m_valid (lane_count_valid),
        .m_ready (lane_count_ready),
        .busy    (count_busy)
    );

    data_joiner u_joiner (
        .clk         (clk),
        .rst         (rst),
        .sum_data    (lane_sum_data),
        .sum_valid   (lane_sum_valid),
        .sum_ready   (lane_sum_ready),
        .count_data  (lane_count_data),
        .count_valid (lane_count_valid),
        .count_ready (lane_count_ready),
        .m_data      (m_data),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .busy        (join_busy)
    );

    // any word still held in a buffer or lane register keeps the block busy
    assign busy = split_busy || sum_busy || count_busy || join_busy;

endmodule

`default_nettype wire

//--- source/stream_pkg.sv
// package with the word widths and vector types of the fork/join datapath

`default_nettype none

package stream_pkg;

    // input word and the two lane results
    localparam int DATA_WIDTH   = 32;
    // four bytes of at most 255 each add up to 1020
    localparam int SUM_WIDTH    = 10;
    // a bit count runs from 0 to 32
    localparam int COUNT_WIDTH  = 6;
    localparam int RESULT_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [SUM_WIDTH-1:0]    sum_t;
    typedef logic [COUNT_WIDTH-1:0]  count_t;

    // output word, count in bits 15..10 and byte sum in bits 9..0
    typedef logic [RESULT_WIDTH-1:0] result_t;

endpackage

`default_nettype wire

//--- stream_fork_join.f
source/stream_pkg.sv
source/pipeline_insert_ff.sv
source/data_splitter.sv
source/byte_sum_lane.sv
source/bit_count_lane.sv
source/data_joiner.sv
source/stream_fork_join.sv
sim/tb_stream_fork_join.sv
